//--- verilog/bridge_config.svh
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// bus widths.
`define ADDR_W 32
`define DATA_W 32
`define AXI_ID_W 4

// extra core reset after the external reset is released.
`define RESET_STRETCH_CYCLES 128

// fixed AXI attributes.
`define AXI_BURST_INCR 2'b01
`define AXI_CACHE_DEFAULT 4'b0000
`define AXI_PROT_DEFAULT 3'b000

`endif

//--- verilog/bridge_pkg.sv
`default_nettype none

`include "bridge_config.svh"

package bridge_pkg;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    typedef enum logic [`AXI_ID_W-1:0] {
        PORT_INST = 0,
        PORT_DATA = 1
    } port_id_e;

    typedef struct packed {
        logic               wr;
        size_e              size;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                 valid;
        logic [`AXI_ID_W-1:0] id;
        logic [`ADDR_W-1:0]   addr;
        logic [3:0]           len;
        logic [2:0]           size;
        logic [1:0]           burst;
        logic [1:0]           lock;
        logic [3:0]           cache;
        logic [2:0]           prot;
    } axi_ar_t;

    typedef axi_ar_t axi_aw_t; // same fields on AW.

    typedef struct packed {
        logic                 valid;
        logic [`AXI_ID_W-1:0] id;
        logic [`DATA_W-1:0]   data;
        logic [1:0]           resp;
        logic                 last;
    } axi_r_t;

    typedef struct packed {
        logic                 valid;
        logic [`AXI_ID_W-1:0] id;
        logic [`DATA_W-1:0]   data;
        logic [`DATA_W/8-1:0] strb;
        logic                 last;
    } axi_w_t;

    typedef struct packed {
        logic                 valid;
        logic [`AXI_ID_W-1:0] id;
        logic [1:0]           resp;
    } axi_b_t;

    function automatic logic [`DATA_W/8-1:0] byte_strobe(size_e size, logic [1:0] addr_lo);
        case (size)
            SIZE_BYTE: byte_strobe = 4'b0001 << addr_lo;
            SIZE_HALF: byte_strobe = addr_lo[1] ? 4'b1100 : 4'b0011;
            default:   byte_strobe = 4'b1111;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- verilog/reset_stretch.sv
`timescale 1ns/100ps
`default_nettype none

`include "bridge_config.svh"

module reset_stretch (
    input  logic Clk,
    input  logic Myreset,
    output logic core_reset_o
);
    localparam int CNT_W = $clog2(`RESET_STRETCH_CYCLES + 1);

    logic [CNT_W-1:0] cnt_q;
    logic             done;

    assign done = (cnt_q == CNT_W'(`RESET_STRETCH_CYCLES)); // saturated.

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            cnt_q <= '0;
        end else if (!done) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign core_reset_o = Myreset | ~done;

endmodule

`default_nettype wire

//--- verilog/req_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "bridge_config.svh"

module req_arbiter import bridge_pkg::*; (
    input  logic               Clk,
    input  logic               core_reset_i,
    input  logic               inst_req_i,
    input  logic [`ADDR_W-1:0] inst_addr_i,
    input  logic               data_req_i,
    input  mem_req_t           data_cmd_i,
    input  logic               rd_busy_i,
    input  logic               wr_busy_i,
    output logic               inst_addr_ok_o,
    output logic               data_addr_ok_o,
    output mem_req_t           rd_req_o,
    output port_id_e           rd_port_o,
    output logic               rd_start_o,
    output mem_req_t           wr_req_o,
    output logic               wr_start_o
);
    mem_req_t inst_cmd;
    port_id_e rd_port_q;
    logic     data_rd_busy;
    logic     rd_free;
    logic     wr_free;
    logic     data_ready;

    assign inst_cmd = '{wr: 1'b0, size: SIZE_WORD, addr: inst_addr_i, wdata: '0};

    // a data write never overlaps a data read, so the two
    // data_ok sources cannot pulse in the same cycle.
    assign data_rd_busy = rd_busy_i & (rd_port_q == PORT_DATA);

    assign rd_free    = ~rd_busy_i & ~wr_busy_i; // reads stay behind writes.
    assign wr_free    = ~wr_busy_i & ~data_rd_busy;
    assign data_ready = data_cmd_i.wr ? wr_free : rd_free;

    assign data_addr_ok_o = data_req_i & data_ready & ~core_reset_i;
    assign inst_addr_ok_o = inst_req_i & ~data_req_i & rd_free & ~core_reset_i;

    assign wr_req_o   = data_cmd_i;
    assign wr_start_o = data_addr_ok_o & data_cmd_i.wr;
    assign rd_start_o = inst_addr_ok_o | (data_addr_ok_o & ~data_cmd_i.wr);

    always_comb begin
        if (data_req_i) begin
            rd_req_o  = data_cmd_i;
            rd_port_o = PORT_DATA;
        end else begin
            rd_req_o  = inst_cmd;
            rd_port_o = PORT_INST;
        end
    end

    always_ff @(posedge Clk) begin
        if (core_reset_i) begin
            rd_port_q <= PORT_INST;
        end else if (rd_start_o) begin
            rd_port_q <= rd_port_o; // owner of the read in flight.
        end
    end

endmodule

`default_nettype wire

//--- verilog/axi_read_channel.sv
`timescale 1ns/100ps
`default_nettype none

`include "bridge_config.svh"

module axi_read_channel import bridge_pkg::*; (
    input  logic               Clk,
    input  logic               core_reset_i,
    input  mem_req_t           rd_req_i,
    input  port_id_e           rd_port_i,
    input  logic               rd_start_i,
    input  logic               arready_i,
    input  axi_r_t             r_i,
    output axi_ar_t            ar_o,
    output logic               rready_o,
    output logic               rd_busy_o,
    output logic               inst_data_ok_o,
    output logic               data_data_ok_o,
    output logic [`DATA_W-1:0] rdata_o
);
    typedef enum logic {
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    rd_state_e          state_q;
    logic               ar_valid_q;
    port_id_e           ar_id_q;
    logic [`ADDR_W-1:0] ar_addr_q;
    size_e              ar_size_q;
    logic               r_take;

    assign rready_o  = (state_q == RD_DATA);
    assign r_take    = rready_o & r_i.valid;
    assign rd_busy_o = ar_valid_q | rready_o;

    always_ff @(posedge Clk) begin
        if (core_reset_i) begin
            state_q        <= RD_ADDR;
            ar_valid_q     <= 1'b0;
            inst_data_ok_o <= 1'b0;
            data_data_ok_o <= 1'b0;
        end else begin
            inst_data_ok_o <= r_take & (r_i.id == PORT_INST); // routed by rid.
            data_data_ok_o <= r_take & (r_i.id == PORT_DATA);
            case (state_q)
                RD_ADDR: begin
                    if (ar_valid_q) begin
                        if (arready_i) begin
                            ar_valid_q <= 1'b0;
                            state_q    <= RD_DATA;
                        end
                    end else if (rd_start_i) begin
                        ar_valid_q <= 1'b1;
                    end
                end
                RD_DATA: begin
                    if (r_i.valid) begin
                        state_q <= RD_ADDR; // single beat.
                    end
                end
                default: state_q <= RD_ADDR;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (rd_start_i) begin
            ar_id_q   <= rd_port_i;
            ar_addr_q <= rd_req_i.addr;
            ar_size_q <= rd_req_i.size;
        end
        if (r_take) begin
            rdata_o <= r_i.data;
        end
    end

    assign ar_o = '{valid: ar_valid_q, id: ar_id_q, addr: ar_addr_q, len: 4'd0,
                    size: {1'b0, ar_size_q}, burst: `AXI_BURST_INCR, lock: 2'b00,
                    cache: `AXI_CACHE_DEFAULT, prot: `AXI_PROT_DEFAULT};

endmodule

`default_nettype wire

//--- verilog/axi_write_channel.sv
`timescale 1ns/100ps
`default_nettype none

`include "bridge_config.svh"

module axi_write_channel import bridge_pkg::*; (
    input  logic     Clk,
    input  logic     core_reset_i,
    input  mem_req_t wr_req_i,
    input  logic     wr_start_i,
    input  logic     awready_i,
    input  logic     wready_i,
    input  axi_b_t   b_i,
    output axi_aw_t  aw_o,
    output axi_w_t   w_o,
    output logic     bready_o,
    output logic     wr_busy_o,
    output logic     wr_done_o
);
    logic                 busy_q;
    logic                 aw_pend_q;
    logic                 w_pend_q;
    logic                 done_q;
    logic                 b_take;
    logic [`ADDR_W-1:0]   addr_q;
    size_e                size_q;
    logic [`DATA_W-1:0]   data_q;
    logic [`DATA_W/8-1:0] strb_q;

    // B is only taken once both AW and W have gone out.
    assign bready_o = busy_q & ~aw_pend_q & ~w_pend_q;
    assign b_take   = bready_o & b_i.valid;

    always_ff @(posedge Clk) begin
        if (core_reset_i) begin
            busy_q    <= 1'b0;
            aw_pend_q <= 1'b0;
            w_pend_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= b_take;
            if (wr_start_i) begin
                busy_q    <= 1'b1;
                aw_pend_q <= 1'b1;
                w_pend_q  <= 1'b1;
            end else begin
                if (aw_pend_q && awready_i) begin
                    aw_pend_q <= 1'b0;
                end
                if (w_pend_q && wready_i) begin
                    w_pend_q <= 1'b0; // independent of AW.
                end
                if (b_take) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (wr_start_i) begin
            addr_q <= wr_req_i.addr;
            size_q <= wr_req_i.size;
            data_q <= wr_req_i.wdata; // bytes already in their lanes.
            strb_q <= byte_strobe(wr_req_i.size, wr_req_i.addr[1:0]);
        end
    end

    assign aw_o = '{valid: aw_pend_q, id: PORT_DATA, addr: addr_q, len: 4'd0,
                    size: {1'b0, size_q}, burst: `AXI_BURST_INCR, lock: 2'b00,
                    cache: `AXI_CACHE_DEFAULT, prot: `AXI_PROT_DEFAULT};

    assign w_o = '{valid: w_pend_q, id: PORT_DATA, data: data_q, strb: strb_q, last: 1'b1};

    assign wr_busy_o = busy_q;
    assign wr_done_o = done_q;

endmodule

`default_nettype wire

//--- verilog/axi_bridge_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "bridge_config.svh"

module axi_bridge_top import bridge_pkg::*; (
    input  logic               Clk,
    input  logic               Myreset,
    input  logic               inst_req_i,
    input  logic [`ADDR_W-1:0] inst_addr_i,
    output logic               inst_addr_ok_o,
    output logic               inst_data_ok_o,
    output logic [`DATA_W-1:0] inst_rdata_o,
    input  logic               data_req_i,
    input  mem_req_t           data_cmd_i,
    output logic               data_addr_ok_o,
    output logic               data_data_ok_o,
    output logic [`DATA_W-1:0] data_rdata_o,
    output axi_ar_t            ar_o,
    input  logic               arready_i,
    input  axi_r_t             r_i,
    output logic               rready_o,
    output axi_aw_t            aw_o,
    input  logic               awready_i,
    output axi_w_t             w_o,
    input  logic               wready_i,
    input  axi_b_t             b_i,
    output logic               bready_o
);
    logic               core_reset;
    mem_req_t           rd_req;
    port_id_e           rd_port;
    logic               rd_start;
    mem_req_t           wr_req;
    logic               wr_start;
    logic               rd_busy;
    logic               wr_busy;
    logic               rd_data_ok;
    logic               wr_done;
    logic [`DATA_W-1:0] rdata;

    reset_stretch u_reset_stretch (
        .Clk          (Clk),
        .Myreset      (Myreset),
        .core_reset_o (core_reset)
    );

    req_arbiter u_req_arbiter (
        .Clk            (Clk),
        .core_reset_i   (core_reset),
        .inst_req_i     (inst_req_i),
        .inst_addr_i    (inst_addr_i),
        .data_req_i     (data_req_i),
        .data_cmd_i     (data_cmd_i),
        .rd_busy_i      (rd_busy),
        .wr_busy_i      (wr_busy),
        .inst_addr_ok_o (inst_addr_ok_o),
        .data_addr_ok_o (data_addr_ok_o),
        .rd_req_o       (rd_req),
        .rd_port_o      (rd_port),
        .rd_start_o     (rd_start),
        .wr_req_o       (wr_req),
        .wr_start_o     (wr_start)
    );

    axi_read_channel u_axi_read_channel (
        .Clk            (Clk),
        .core_reset_i   (core_reset),
        .rd_req_i       (rd_req),
        .rd_port_i      (rd_port),
        .rd_start_i     (rd_start),
        .arready_i      (arready_i),
        .r_i            (r_i),
        .ar_o           (ar_o),
        .rready_o       (rready_o),
        .rd_busy_o      (rd_busy),
        .inst_data_ok_o (inst_data_ok_o),
        .data_data_ok_o (rd_data_ok),
        .rdata_o        (rdata)
    );

    axi_write_channel u_axi_write_channel (
        .Clk          (Clk),
        .core_reset_i (core_reset),
        .wr_req_i     (wr_req),
        .wr_start_i   (wr_start),
        .awready_i    (awready_i),
        .wready_i     (wready_i),
        .b_i          (b_i),
        .aw_o         (aw_o),
        .w_o          (w_o),
        .bready_o     (bready_o),
        .wr_busy_o    (wr_busy),
        .wr_done_o    (wr_done)
    );

    assign data_data_ok_o = rd_data_ok | wr_done; // read or write completion.
    assign inst_rdata_o   = rdata;
    assign data_rdata_o   = rdata;

endmodule

`default_nettype wire

//--- bench/tb_axi_bridge.sv
`timescale 1ns/100ps
`default_nettype none

`include "bridge_config.svh"

module tb_axi_bridge import bridge_pkg::*; ();
    localparam int TIMEOUT = 200;

    logic               Clk;
    logic               Myreset;
    logic               inst_req_i;
    logic [`ADDR_W-1:0] inst_addr_i;
    logic               inst_addr_ok_o;
    logic               inst_data_ok_o;
    logic [`DATA_W-1:0] inst_rdata_o;
    logic               data_req_i;
    mem_req_t           data_cmd_i;
    logic               data_addr_ok_o;
    logic               data_data_ok_o;
    logic [`DATA_W-1:0] data_rdata_o;
    axi_ar_t            ar_o;
    logic               arready_i;
    axi_r_t             r_i;
    logic               rready_o;
    axi_aw_t            aw_o;
    logic               awready_i;
    axi_w_t             w_o;
    logic               wready_i;
    axi_b_t             b_i;
    logic               bready_o;

    axi_bridge_top dut0 (.*);

    int errors = 0;
    int pass_n = 0;
    int fail_n = 0;
    int inst_ok_n = 0;
    int data_ok_n = 0;

    logic [`DATA_W-1:0] mem [logic [`ADDR_W-1:0]];
    logic [`DATA_W-1:0] ref_mem [logic [`ADDR_W-1:0]];
    axi_ar_t ar_log[$];
    axi_aw_t aw_log[$];
    axi_w_t  w_log[$];

    always #20 Clk = ~Clk;

    function automatic logic [`DATA_W-1:0] init_word(logic [`ADDR_W-1:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [`DATA_W-1:0] merge(logic [`DATA_W-1:0] old_w,
                                                 logic [`DATA_W-1:0] new_w, logic [3:0] strb);
        logic [`DATA_W-1:0] res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[8*i +: 8] = new_w[8*i +: 8];
        end
        return res;
    endfunction

    function automatic logic [3:0] lane_mask(size_e sz, logic [1:0] lo);
        if (sz == SIZE_WORD) return 4'hf;
        if (sz == SIZE_HALF) return lo[1] ? 4'hc : 4'h3;
        return 4'h1 << lo;
    endfunction

    // expected content of a word, from the reference copy.
    function automatic logic [`DATA_W-1:0] ref_word(logic [`ADDR_W-1:0] a);
        logic [`ADDR_W-1:0] wa;
        wa = {a[31:2], 2'b00};
        return ref_mem.exists(wa) ? ref_mem[wa] : init_word(wa);
    endfunction

    function automatic axi_ar_t exp_addr(logic [3:0] id, logic [`ADDR_W-1:0] a, size_e sz);
        return '{valid: 1'b1, id: id, addr: a, len: 4'd0, size: {1'b0, sz},
                 burst: `AXI_BURST_INCR, lock: 2'b00, cache: `AXI_CACHE_DEFAULT,
                 prot: `AXI_PROT_DEFAULT};
    endfunction

    task automatic check_ar(string name, axi_ar_t exp, axi_ar_t act);
        if (exp !== act) begin
            $display("** Error t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_aw(string name, axi_aw_t exp, axi_aw_t act);
        if (exp !== act) begin
            $display("** Error t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_w(string name, axi_w_t exp, axi_w_t act);
        if (exp !== act) begin
            $display("** Error t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(string name, logic [`DATA_W-1:0] exp, logic [`DATA_W-1:0] act);
        if (exp !== act) begin
            $display("** Error t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("** Error t=%0t %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic timed_out(string what);
        $display("timeout at %0t: %s never came", $time, what);
        errors++;
    endtask

    task automatic report(string name, int err_before);
        if (errors == err_before) begin
            pass_n++;
            $display("test %s: ok", name);
        end else begin
            fail_n++;
            $display("test %s: FAILED", name);
        end
    endtask

    // slave model with random ready delays and a valid/field stability monitor.
    int      ar_cnt, aw_cnt, w_cnt, r_cnt;
    logic    rd_pend, aw_got, w_got, ar_wait, aw_wait, w_wait;
    logic [3:0]         rd_id;
    logic [`ADDR_W-1:0] rd_addr, wr_addr;
    logic [`DATA_W-1:0] wr_data;
    logic [3:0]         wr_strb;
    axi_ar_t ar_prev;
    axi_aw_t aw_prev;
    axi_w_t  w_prev;

    always @(posedge Clk) begin
        if (inst_data_ok_o) inst_ok_n <= inst_ok_n + 1;
        if (data_data_ok_o) data_ok_n <= data_ok_n + 1;
        if (ar_wait) check_ar("ar_o held", ar_prev, ar_o);
        if (aw_wait) check_aw("aw_o held", aw_prev, aw_o);
        if (w_wait) check_w("w_o held", w_prev, w_o);
        if (!Myreset) begin
            // ready only while the slave owes a beat.
            check_bit("rready_o", rd_pend | r_i.valid, rready_o);
            check_bit("bready_o", (aw_got & w_got) | b_i.valid, bready_o);
        end
        ar_wait = ar_o.valid && !arready_i;
        aw_wait = aw_o.valid && !awready_i;
        w_wait  = w_o.valid && !wready_i;
        ar_prev = ar_o;
        aw_prev = aw_o;
        w_prev  = w_o;
        if (ar_o.valid && arready_i) begin
            ar_log.push_back(ar_o);
            arready_i <= 1'b0;
            ar_cnt    <= $urandom % 4;
            rd_id     <= ar_o.id;
            rd_addr   <= {ar_o.addr[31:2], 2'b00};
            rd_pend   <= 1'b1;
            r_cnt     <= $urandom % 4;
        end else if (ar_o.valid) begin
            if (ar_cnt == 0) arready_i <= 1'b1;
            else ar_cnt <= ar_cnt - 1;
        end
        if (r_i.valid && rready_o) begin
            r_i.valid <= 1'b0;
        end else if (rd_pend && !r_i.valid) begin
            if (r_cnt == 0) begin
                r_i     <= '{valid: 1'b1, id: rd_id, resp: 2'b00, last: 1'b1,
                             data: mem.exists(rd_addr) ? mem[rd_addr] : init_word(rd_addr)};
                rd_pend <= 1'b0;
            end else begin
                r_cnt <= r_cnt - 1;
            end
        end
        if (aw_o.valid && awready_i) begin
            aw_log.push_back(aw_o);
            awready_i <= 1'b0;
            aw_cnt    <= $urandom % 4;
            wr_addr   <= {aw_o.addr[31:2], 2'b00};
            aw_got    <= 1'b1;
        end else if (aw_o.valid) begin
            if (aw_cnt == 0) awready_i <= 1'b1;
            else aw_cnt <= aw_cnt - 1;
        end
        if (w_o.valid && wready_i) begin
            w_log.push_back(w_o);
            wready_i <= 1'b0;
            w_cnt    <= $urandom % 4;
            wr_data  <= w_o.data;
            wr_strb  <= w_o.strb;
            w_got    <= 1'b1;
        end else if (w_o.valid) begin
            if (w_cnt == 0) wready_i <= 1'b1;
            else w_cnt <= w_cnt - 1;
        end
        if (b_i.valid && bready_o) begin
            b_i.valid <= 1'b0;
        end else if (aw_got && w_got && !b_i.valid) begin
            mem[wr_addr] = merge(mem.exists(wr_addr) ? mem[wr_addr] : init_word(wr_addr),
                                 wr_data, wr_strb);
            b_i    <= '{valid: 1'b1, id: PORT_DATA, resp: 2'b00};
            aw_got <= 1'b0;
            w_got  <= 1'b0;
        end
    end

    task automatic inst_fetch(logic [`ADDR_W-1:0] a, output logic [`DATA_W-1:0] rd);
        int n;
        inst_req_i  <= 1'b1;
        inst_addr_i <= a;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge Clk);
            if (inst_addr_ok_o) break;
        end
        if (n == TIMEOUT) timed_out("inst_addr_ok_o");
        inst_req_i <= 1'b0;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge Clk);
            if (inst_data_ok_o) break;
        end
        if (n == TIMEOUT) timed_out("inst_data_ok_o");
        rd = inst_rdata_o;
    endtask

    task automatic data_op(mem_req_t cmd, output logic [`DATA_W-1:0] rd);
        int n;
        data_req_i <= 1'b1;
        data_cmd_i <= cmd;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge Clk);
            if (data_addr_ok_o) break;
        end
        if (n == TIMEOUT) timed_out("data_addr_ok_o");
        data_req_i <= 1'b0;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge Clk);
            if (data_data_ok_o) break;
        end
        if (n == TIMEOUT) timed_out("data_data_ok_o");
        rd = data_rdata_o;
    endtask

    task automatic expect_read(logic [3:0] id, logic [`ADDR_W-1:0] a, size_e sz,
                               logic [`DATA_W-1:0] rd);
        if (ar_log.size() == 0) begin
            $display("no AR handshake was seen for address %h", a);
            errors++;
        end else begin
            check_ar("ar_o", exp_addr(id, a, sz), ar_log.pop_front());
        end
        check_word("rdata", ref_word(a), rd);
    endtask

    task automatic do_write(logic [`ADDR_W-1:0] a, size_e sz, logic [`DATA_W-1:0] d);
        logic [`DATA_W-1:0] rd;
        logic [3:0]         strb;
        strb = lane_mask(sz, a[1:0]);
        data_op('{wr: 1'b1, size: sz, addr: a, wdata: d}, rd);
        ref_mem[{a[31:2], 2'b00}] = merge(ref_word(a), d, strb);
        if (aw_log.size() == 0 || w_log.size() == 0) begin
            $display("write to %h completed without both AW and W", a);
            errors++;
        end else begin
            check_aw("aw_o", exp_addr(PORT_DATA, a, sz), aw_log.pop_front());
            check_w("w_o", '{valid: 1'b1, id: PORT_DATA, data: d, strb: strb, last: 1'b1},
                    w_log.pop_front());
        end
    endtask

    task automatic do_read(logic [`ADDR_W-1:0] a);
        logic [`DATA_W-1:0] rd;
        data_op('{wr: 1'b0, size: SIZE_WORD, addr: a, wdata: '0}, rd);
        expect_read(PORT_DATA, a, SIZE_WORD, rd);
    endtask

    initial begin
        int e, n, low, d_before, i_before;
        logic [`DATA_W-1:0] rd;
        logic [`ADDR_W-1:0] a;
        logic d_acc, i_acc, d_ok, i_ok;
        void'($urandom(88125));
        Clk = 1'b0;
        Myreset <= 1'b1;
        inst_req_i <= 1'b0;
        inst_addr_i <= '0;
        data_req_i <= 1'b0;
        data_cmd_i <= '0;
        arready_i <= 1'b0;
        awready_i <= 1'b0;
        wready_i <= 1'b0;
        r_i <= '0;
        b_i <= '0;
        {ar_cnt, aw_cnt, w_cnt, r_cnt} = '0;
        {rd_pend, aw_got, w_got, ar_wait, aw_wait, w_wait} = '0;
        repeat (8) @(posedge Clk);
        Myreset     <= 1'b0;
        inst_req_i  <= 1'b1; // held from the release.
        inst_addr_i <= 32'h0000_0040;

        e = errors;
        for (low = 0; low < `RESET_STRETCH_CYCLES + TIMEOUT; low++) begin
            @(posedge Clk);
            if (ar_o.valid) check_word("ar_o.valid", 0, 1);
            if (inst_addr_ok_o) break;
        end
        check_word("addr_ok low cycles", `RESET_STRETCH_CYCLES, low);
        inst_req_i <= 1'b0;
        report("reset stretch", e);

        e = errors;
        d_before = data_ok_n;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge Clk);
            if (inst_data_ok_o) break;
        end
        if (n == TIMEOUT) timed_out("inst_data_ok_o");
        expect_read(PORT_INST, 32'h0000_0040, SIZE_WORD, inst_rdata_o);
        @(posedge Clk);
        check_word("data_data_ok_o count", d_before, data_ok_n);
        report("instruction fetch", e);

        e = errors;
        do_write(32'h0000_0101, SIZE_BYTE, {4{8'ha5}});
        do_write(32'h0000_0102, SIZE_HALF, {2{16'hbeef}});
        do_write(32'h0000_0104, SIZE_WORD, 32'h1234_5678);
        do_write(32'h0000_0108, SIZE_HALF, {2{16'hc001}});
        report("data writes", e);

        e = errors;
        do_read(32'h0000_0100);
        do_read(32'h0000_0104);
        do_read(32'h0000_0108);
        report("read after write", e);

        e = errors;
        {d_acc, i_acc, d_ok, i_ok} = '0;
        data_req_i  <= 1'b1;
        data_cmd_i  <= '{wr: 1'b0, size: SIZE_WORD, addr: 32'h0000_0104, wdata: '0};
        inst_req_i  <= 1'b1;
        inst_addr_i <= 32'h0000_0200;
        for (n = 0; n < TIMEOUT && !(d_ok && i_ok); n++) begin
            @(posedge Clk);
            if (data_addr_ok_o) begin
                d_acc = 1'b1;
                data_req_i <= 1'b0;
            end
            if (inst_addr_ok_o) begin
                if (!d_acc) begin
                    $display("instruction request accepted before the data request");
                    errors++;
                end
                i_acc = 1'b1;
                inst_req_i <= 1'b0;
            end
            if (data_data_ok_o) d_ok = 1'b1;
            if (inst_data_ok_o) begin
                i_ok = 1'b1;
                check_word("inst_rdata_o", ref_word(32'h0000_0200), inst_rdata_o);
            end
        end
        if (!(d_ok && i_ok)) timed_out("completion of both prioritized requests");
        if (ar_log.size() == 2) begin
            check_ar("ar_o first", exp_addr(PORT_DATA, 32'h0000_0104, SIZE_WORD),
                     ar_log.pop_front());
            check_ar("ar_o second", exp_addr(PORT_INST, 32'h0000_0200, SIZE_WORD),
                     ar_log.pop_front());
        end else begin
            $display("expected two AR handshakes, saw %0d", ar_log.size());
            errors++;
        end
        report("priority", e);

        e = errors;
        @(posedge Clk);
        d_before = data_ok_n;
        i_before = inst_ok_n;
        low = 0;
        for (int k = 0; k < 24; k++) begin
            a = {26'h0, 4'($urandom % 16), 2'b00} + 32'h0000_0300;
            case ($urandom % 3)
                0: begin
                    inst_fetch(a, rd);
                    expect_read(PORT_INST, a, SIZE_WORD, rd);
                    low++;
                end
                1: do_write(a, SIZE_WORD, $urandom);
                default: do_read(a);
            endcase
        end
        repeat (4) @(posedge Clk);
        check_word("inst completions", i_before + low, inst_ok_n);
        check_word("data completions", d_before + 24 - low, data_ok_n);
        report("back-pressure", e);

        $display("tests passed %0d, failed %0d, errors %0d", pass_n, fail_n, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verilog
verilog/bridge_pkg.sv
verilog/reset_stretch.sv
verilog/req_arbiter.sv
verilog/axi_read_channel.sv
verilog/axi_write_channel.sv
verilog/axi_bridge_top.sv
bench/tb_axi_bridge.sv

//--- Bender.yml
package:
  name: axi_bridge

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/bridge_pkg.sv
      - verilog/reset_stretch.sv
      - verilog/req_arbiter.sv
      - verilog/axi_read_channel.sv
      - verilog/axi_write_channel.sv
      - verilog/axi_bridge_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - bench/tb_axi_bridge.sv
